// ==== mem_req_pkg.sv ====
// Request types for the memory queue; addresses must be naturally aligned and QDEP a power of two above one
package mem_req_pkg;

	// ============================================================
	// Queue sizing
	// ============================================================

	// Number of queue entries
	localparam int QDEP = 8;
	// Index width of the queue, the counter is one bit wider
	localparam int QAW = $clog2(QDEP);

	// ============================================================
	// Request and result formats
	// ============================================================

	// MR_LOAD sign extends, MR_LOADZ zero extends
	typedef enum logic [1:0] {
		MR_LOAD  = 2'd0,
		MR_LOADZ = 2'd1,
		MR_STORE = 2'd2
	} mem_func_e;

	// Access sizes of 1, 2, 4 and 8 bytes
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} mem_size_e;

	// Store data is right-justified, adr is a byte address
	typedef struct packed {
		mem_func_e   func;
		mem_size_e   sz;
		logic [3:0]  tag;
		logic [31:0] adr;
		logic [63:0] dat;
	} mem_req_t;

	// Load result with the data already extended to 64 bits
	typedef struct packed {
		logic [3:0]  tag;
		logic [63:0] dat;
	} mem_rsp_t;

	// Byte lanes touched by an access within its 8-byte word
	function automatic logic [7:0] byte_mask(mem_size_e sz, logic [2:0] ofs);
		logic [7:0] low;
		case (sz)
			SZ_BYTE:  low = 8'h01;
			SZ_WYDE:  low = 8'h03;
			SZ_TETRA: low = 8'h0f;
			default:  low = 8'hff;
		endcase
		return low << ofs;
	endfunction

	// Trims right-justified load data to its size and extends it
	function automatic logic [63:0] extend_load(mem_func_e func, mem_size_e sz, logic [63:0] d);
		logic s;
		case (sz)
			SZ_BYTE: begin
				s = (func == MR_LOAD) && d[7];
				return {{56{s}}, d[7:0]};
			end
			SZ_WYDE: begin
				s = (func == MR_LOAD) && d[15];
				return {{48{s}}, d[15:0]};
			end
			SZ_TETRA: begin
				s = (func == MR_LOAD) && d[31];
				return {{32{s}}, d[31:0]};
			end
			default: return d;
		endcase
	endfunction

endpackage

// ==== wb_pkg.sv ====
// Wishbone classic signal bundles; 32-bit byte addresses and one 64-bit data bus with byte selects
package wb_pkg;

	// ============================================================
	// Bus widths
	// ============================================================

	localparam int AWID = 32;
	localparam int DWID = 64;

	// Master to slave, cyc and stb always move together in this design
	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic            we;
		logic [AWID-1:0] adr;
		logic [DWID/8-1:0] sel;
		logic [DWID-1:0] dat;
	} wb_m2s_t;

	// Slave to master, dat only matters in the ack cycle of a read
	typedef struct packed {
		logic            ack;
		logic [DWID-1:0] dat;
	} wb_s2m_t;

endpackage

// ==== mem_req_queue.sv ====
// In-order request queue; issuers must hold wrN and iN until wr_ackN and at most one port is taken per cycle
module mem_req_queue import mem_req_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr0,
	input  mem_req_t i0,
	input  logic     wr1,
	input  mem_req_t i1,
	input  logic     pop,
	output logic     wr_ack0,
	output logic     wr_ack1,
	output mem_req_t head,
	output logic     head_valid,
	output logic     empty,
	output logic     full,
	output logic     fwd_valid,
	output mem_rsp_t fwd_rsp
);

	// ============================================================
	// Queue storage
	// ============================================================

	// Entry 0 is the oldest request and the one on the bus
	mem_req_t        que [QDEP];
	logic [7:0]      msk [QDEP];
	logic [QAW:0]    cnt;
	logic [QDEP-1:0] val;

	// Per-port views so both ports share one search
	mem_req_t    req [2];
	logic        wr [2];
	logic        ack [2];
	logic        fwd [2];
	logic        ovl [2];
	logic [63:0] fdat [2];
	logic        take [2];

	logic         do_pop;
	logic         room;
	logic         sel1;
	mem_req_t     c_req;
	logic         c_fwd;
	logic [63:0]  c_fdat;
	logic         do_push;
	logic [QAW:0] widx;

	assign req[0] = i0;
	assign req[1] = i1;
	assign wr[0]  = wr0;
	assign wr[1]  = wr1;
	// A port that was just acknowledged still shows its old request
	assign ack[0] = wr_ack0;
	assign ack[1] = wr_ack1;

	// Valid bits follow from the fill count since entries are packed at the bottom
	for (genvar e = 0; e < QDEP; e++) begin : g_val
		assign val[e] = (QAW+1)'(e) < cnt;
	end

	assign empty      = (cnt == '0);
	assign full       = (cnt == (QAW+1)'(QDEP));
	assign head_valid = !empty;
	assign head       = que[0];
	assign do_pop     = pop && !empty;
	// A slot frees up in the same cycle when the head leaves
	assign room       = !full || do_pop;

	// ============================================================
	// Store search, one copy per issue port
	// ============================================================

	for (genvar p = 0; p < 2; p++) begin : g_port
		logic [7:0] rmsk;
		logic       is_st;

		assign rmsk  = byte_mask(req[p].sz, req[p].adr[2:0]);
		assign is_st = (req[p].func == MR_STORE);

		always_comb begin : search
			logic [2:0] diff;
			fwd[p]  = 1'b0;
			ovl[p]  = 1'b0;
			fdat[p] = '0;
			diff    = '0;
			// Later entries are younger, so the last match wins
			for (int n = 0; n < QDEP; n++) begin
				if (val[n] && que[n].func == MR_STORE &&
					que[n].adr[31:3] == req[p].adr[31:3]) begin
					if ((msk[n] & rmsk) != 8'h00)
						ovl[p] = 1'b1;
					// Full cover means the load never needs memory
					if (!is_st && (msk[n] & rmsk) == rmsk) begin
						diff    = req[p].adr[2:0] - que[n].adr[2:0];
						fwd[p]  = 1'b1;
						fdat[p] = que[n].dat >> {diff, 3'b000};
					end
				end
			end
		end

		// Stores that touch any queued store bytes wait for it to drain
		assign take[p] = wr[p] && !ack[p] && room && !(is_st && ovl[p]);
	end

	// ============================================================
	// Port selection and queue update
	// ============================================================

	// Port 0 wins whenever it can be taken
	assign sel1    = take[1] && !take[0];
	assign c_req   = take[0] ? i0 : i1;
	assign c_fwd   = take[0] ? fwd[0] : fwd[1];
	assign c_fdat  = take[0] ? fdat[0] : fdat[1];
	assign do_push = (take[0] || sel1) && !c_fwd;
	// Write slot is one lower when the queue shifts in the same cycle
	assign widx    = cnt - (QAW+1)'(do_pop);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ack0   <= 1'b0;
			wr_ack1   <= 1'b0;
			fwd_valid <= 1'b0;
			cnt       <= '0;
		end else begin
			wr_ack0   <= take[0];
			wr_ack1   <= sel1;
			// The forwarded result goes out together with the acknowledge
			fwd_valid <= (take[0] || sel1) && c_fwd;
			cnt       <= cnt + (QAW+1)'(do_push) - (QAW+1)'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_pop) begin
			for (int n = 0; n < QDEP - 1; n++) begin
				que[n] <= que[n+1];
				msk[n] <= msk[n+1];
			end
		end
		// Placed after the shift so the new entry overrides a moved one
		if (do_push) begin
			que[widx[QAW-1:0]] <= c_req;
			msk[widx[QAW-1:0]] <= byte_mask(c_req.sz, c_req.adr[2:0]);
		end
		fwd_rsp.tag <= c_req.tag;
		fwd_rsp.dat <= extend_load(c_req.func, c_req.sz, c_fdat);
	end

endmodule

// ==== wb_mem_master.sv ====
// Wishbone classic master for the queue head; one cycle at a time with an idle cycle after each ack
module wb_mem_master import mem_req_pkg::*, wb_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  mem_req_t head,
	input  logic     head_valid,
	input  wb_s2m_t  wb_i,
	output logic     pop,
	output wb_m2s_t  wb_o,
	output logic     mem_valid,
	output mem_rsp_t mem_rsp
);

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUS  = 1'b1
	} state_e;

	state_e     st;
	logic       done;
	logic [5:0] lane;

	// Bit offset of the access within the 64-bit word
	assign lane = {head.adr[2:0], 3'b000};
	assign done = (st == ST_BUS) && wb_i.ack;

	// ============================================================
	// Bus outputs
	// ============================================================

	// The head only changes on pop, which comes after ack, so the
	// address phase stays stable without extra registers
	assign wb_o.cyc = (st == ST_BUS);
	assign wb_o.stb = (st == ST_BUS);
	assign wb_o.we  = (head.func == MR_STORE);
	assign wb_o.adr = {head.adr[AWID-1:3], 3'b000};
	assign wb_o.sel = byte_mask(head.sz, head.adr[2:0]);
	assign wb_o.dat = head.dat << lane;

	// ============================================================
	// Cycle control
	// ============================================================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			st        <= ST_IDLE;
			pop       <= 1'b0;
			mem_valid <= 1'b0;
		end else begin
			pop       <= 1'b0;
			mem_valid <= 1'b0;
			case (st)
				ST_IDLE: begin
					// While pop is high the head still shows the old entry
					if (head_valid && !pop)
						st <= ST_BUS;
				end
				default: begin
					if (wb_i.ack) begin
						st        <= ST_IDLE;
						pop       <= 1'b1;
						mem_valid <= (head.func != MR_STORE);
					end
				end
			endcase
		end
	end

	// Load data is pulled down from its lanes and extended
	always_ff @(posedge clk) begin
		if (done) begin
			mem_rsp.tag <= head.tag;
			mem_rsp.dat <= extend_load(head.func, head.sz, wb_i.dat >> lane);
		end
	end

endmodule

// ==== load_result_merge.sv ====
// Result merge with a one-entry hold; assumes a forwarded result never arrives on every cycle for long
module load_result_merge import mem_req_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     fwd_valid,
	input  mem_rsp_t fwd_rsp,
	input  logic     mem_valid,
	input  mem_rsp_t mem_rsp,
	output logic     rsp_valid,
	output mem_rsp_t rsp
);

	mem_rsp_t hold;
	logic     hold_v;
	logic     park;

	// Memory result must wait when the slot is taken by a forward or the hold
	assign park = mem_valid && (fwd_valid || hold_v);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rsp_valid <= 1'b0;
			hold_v    <= 1'b0;
		end else begin
			rsp_valid <= fwd_valid || hold_v || mem_valid;
			// The hold empties only in a cycle without a forward
			hold_v    <= park || (hold_v && fwd_valid);
		end
	end

	// Priority is forward, then held result, then fresh memory result
	always_ff @(posedge clk) begin
		if (fwd_valid)
			rsp <= fwd_rsp;
		else if (hold_v)
			rsp <= hold;
		else
			rsp <= mem_rsp;
		if (park)
			hold <= mem_rsp;
	end

endmodule

// ==== mem_req_subsys.sv ====
// Memory request subsystem top; data memory sits outside on the Wishbone port
module mem_req_subsys import mem_req_pkg::*, wb_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr0,
	input  logic     wr1,
	input  mem_req_t i0,
	input  mem_req_t i1,
	input  wb_s2m_t  wb_i,
	output logic     wr_ack0,
	output logic     wr_ack1,
	output wb_m2s_t  wb_o,
	output logic     rsp_valid,
	output mem_rsp_t rsp,
	output logic     empty,
	output logic     full
);

	// ============================================================
	// Internal links
	// ============================================================

	mem_req_t head;
	logic     head_valid;
	logic     pop;
	logic     fwd_valid;
	mem_rsp_t fwd_rsp;
	logic     mem_valid;
	mem_rsp_t mem_rsp;

	// Accepts requests, forwards covered loads, feeds the bus master
	mem_req_queue queue_i (
		.clk        (clk),
		.rst        (rst),
		.wr0        (wr0),
		.i0         (i0),
		.wr1        (wr1),
		.i1         (i1),
		.pop        (pop),
		.wr_ack0    (wr_ack0),
		.wr_ack1    (wr_ack1),
		.head       (head),
		.head_valid (head_valid),
		.empty      (empty),
		.full       (full),
		.fwd_valid  (fwd_valid),
		.fwd_rsp    (fwd_rsp)
	);

	wb_mem_master master_i (
		.clk        (clk),
		.rst        (rst),
		.head       (head),
		.head_valid (head_valid),
		.wb_i       (wb_i),
		.pop        (pop),
		.wb_o       (wb_o),
		.mem_valid  (mem_valid),
		.mem_rsp    (mem_rsp)
	);

	// Both result sources end up on the single result port
	load_result_merge merge_i (
		.clk       (clk),
		.rst       (rst),
		.fwd_valid (fwd_valid),
		.fwd_rsp   (fwd_rsp),
		.mem_valid (mem_valid),
		.mem_rsp   (mem_rsp),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

// ==== mem_req_asserts.sv ====
// Bus and handshake assertions for mem_req_subsys; checks are off while rst is high except the reset one
module mem_req_asserts import wb_pkg::*; (
	input logic    clk,
	input logic    rst,
	input logic    wr_ack0,
	input logic    wr_ack1,
	input logic    full,
	input logic    pop,
	input logic    rsp_valid,
	input wb_m2s_t wb_o,
	input wb_s2m_t wb_i
);
	timeunit 1ns;
	timeprecision 1ns;

	// Number of assertion failures so far
	int fails = 0;

	// An acknowledge is a single-cycle pulse
	ack0_pulse: assert property (@(posedge clk) disable iff (rst) wr_ack0 |=> !wr_ack0)
		else begin fails++; $error("wr_ack0 high two cycles in a row"); end
	ack1_pulse: assert property (@(posedge clk) disable iff (rst) wr_ack1 |=> !wr_ack1)
		else begin fails++; $error("wr_ack1 high two cycles in a row"); end

	// ============================================================
	// Wishbone classic cycle holds until ack
	// ============================================================

	bus_hold: assert property (@(posedge clk) disable iff (rst)
		wb_o.cyc && wb_o.stb && !wb_i.ack |=> wb_o.cyc && wb_o.stb &&
		$stable(wb_o.adr) && $stable(wb_o.sel) && $stable(wb_o.we) && $stable(wb_o.dat))
		else begin fails++; $error("bus cycle changed before ack"); end

	// A full queue with no pop has no slot to accept into
	full_no_ack: assert property (@(posedge clk) disable iff (rst)
		full && !pop |=> !wr_ack0 && !wr_ack1)
		else begin fails++; $error("request acknowledged while full"); end

	reset_idle: assert property (@(posedge clk) rst |-> !rsp_valid && !wb_o.cyc)
		else begin fails++; $error("rsp_valid or cyc high during reset"); end

endmodule

bind mem_req_subsys mem_req_asserts asserts_i (
	.clk       (clk),
	.rst       (rst),
	.wr_ack0   (wr_ack0),
	.wr_ack1   (wr_ack1),
	.full      (full),
	.pop       (pop),
	.rsp_valid (rsp_valid),
	.wb_o      (wb_o),
	.wb_i      (wb_i)
);

// ==== tb_mem_req_subsys.sv ====
// Testbench for mem_req_subsys; memory model covers byte addresses 0 to 0x7ff only
module tb_mem_req_subsys import mem_req_pkg::*, wb_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	// Six tests of at most about 400 cycles each, plus margin for reset
	localparam int MAX_CYCLES = 3000;

	logic     clk = 1'b0;
	logic     rst;
	logic     wr0, wr1;
	mem_req_t i0, i1;
	wb_s2m_t  wb_i;
	logic     wr_ack0, wr_ack1, rsp_valid, empty, full;
	wb_m2s_t  wb_o;
	mem_rsp_t rsp;

	// Model memory and the shadow that predicts it
	logic [7:0]  mem_b [2048];
	logic [7:0]  shadow [2048];
	logic [63:0] exp_dat [16];
	logic        exp_pend [16];
	logic [3:0]  issued [$];
	logic [3:0]  got [$];
	integer      seed = 8425;
	int          wcnt, cycles, errors, checks, pending, tests;
	logic        stall;
	logic [3:0]  next_tag;

	mem_req_subsys dut_i (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ============================================================
	// Wishbone memory model, acks after 1 to 3 wait cycles
	// ============================================================

	always @(posedge clk) begin
		wb_i.ack <= 1'b0;
		if (wb_o.cyc && wb_o.stb && !wb_i.ack && !stall) begin
			if (wcnt == 0) begin
				wb_i.ack <= 1'b1;
				for (int k = 0; k < 8; k++) begin
					wb_i.dat[8*k +: 8] <= mem_b[{wb_o.adr[10:3], 3'(k)}];
					if (wb_o.we && wb_o.sel[k])
						mem_b[{wb_o.adr[10:3], 3'(k)}] <= wb_o.dat[8*k +: 8];
				end
				wcnt <= 1 + ($unsigned($random(seed)) % 3);
			end else
				wcnt <= wcnt - 1;
		end
	end

	// Every result must match a pending load with the same tag
	always @(negedge clk) begin
		if (!rst && rsp_valid) begin
			checks++;
			if (!exp_pend[rsp.tag]) begin
				$display("result with tag %0d arrived but no load was waiting for it", rsp.tag);
				errors++;
			end else begin
				if (rsp.dat !== exp_dat[rsp.tag]) begin
					$display("mismatch at %0t: rsp.dat expected %h got %h", $time,
						exp_dat[rsp.tag], rsp.dat);
					errors++;
				end
				exp_pend[rsp.tag] = 1'b0;
				pending--;
			end
			got.push_back(rsp.tag);
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	function automatic mem_req_t make_req(mem_func_e f, mem_size_e s, logic [31:0] a,
		logic [63:0] d);
		mem_req_t r;
		r = '{func: f, sz: s, tag: next_tag, adr: a, dat: d};
		next_tag = next_tag + 4'd1;
		return r;
	endfunction

	// Little-endian bytes from the shadow, extended by the load function
	function automatic logic [63:0] predict_load(mem_req_t r);
		logic [63:0] v;
		int          n;
		n = 1 << r.sz;
		v = '0;
		for (int k = 0; k < n; k++)
			v[8*k +: 8] = shadow[11'(r.adr + k)];
		if (r.func == MR_LOAD && n < 8 && v[8*n-1])
			for (int k = n; k < 8; k++)
				v[8*k +: 8] = 8'hff;
		return v;
	endfunction

	function automatic void record(mem_req_t r);
		if (r.func == MR_STORE) begin
			for (int k = 0; k < (1 << r.sz); k++)
				shadow[11'(r.adr + k)] = r.dat[8*k +: 8];
		end else begin
			exp_dat[r.tag]  = predict_load(r);
			exp_pend[r.tag] = 1'b1;
			pending++;
			issued.push_back(r.tag);
		end
	endfunction

	task automatic expect_true(input logic cond, input string what);
		checks++;
		if (!cond) begin
			$display("check failed at %0t: %s", $time, what);
			errors++;
		end
	endtask

	// Offers on one port, holds until acknowledged, then drops the offer
	task automatic issue(input int p, input mem_req_t r);
		@(posedge clk);
		if (p == 0) begin
			wr0 <= 1'b1;
			i0  <= r;
		end else begin
			wr1 <= 1'b1;
			i1  <= r;
		end
		do @(negedge clk); while (!(p == 0 ? wr_ack0 : wr_ack1));
		record(r);
		@(posedge clk);
		if (p == 0)
			wr0 <= 1'b0;
		else
			wr1 <= 1'b0;
	endtask

	task automatic drain();
		do @(negedge clk); while (!(empty && pending == 0));
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "errors");
	endtask

	// ============================================================
	// Tests
	// ============================================================

	initial begin
		mem_req_t r, q;
		int       e0;
		rst = 1'b1;
		wr0 = 1'b0;
		wr1 = 1'b0;
		i0 = '0;
		i1 = '0;
		wb_i = '0;
		stall = 1'b0;
		wcnt = 1;
		cycles = 0;
		errors = 0;
		checks = 0;
		pending = 0;
		tests = 0;
		next_tag = '0;
		for (int a = 0; a < 2048; a++) begin
			mem_b[a]  = 8'(a) ^ (8'(a >> 8) * 8'h3b) ^ 8'h5a;
			shadow[a] = mem_b[a];
			exp_pend[a % 16] = 1'b0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		e0 = errors;
		@(negedge clk);
		expect_true(!wr_ack0 && !wr_ack1 && !wb_o.cyc && !wb_o.stb && !rsp_valid,
			"outputs not idle after reset");
		expect_true(empty && !full, "queue not empty after reset");
		finish_test("reset state", e0);

		// Stalled bus keeps the store queued so every load is forwarded
		e0 = errors;
		stall = 1'b1;
		issue(0, make_req(MR_STORE, SZ_OCTA, 32'h40, 64'h80f1_7e82_93a4_b5c6));
		for (int k = 0; k < 6; k++) begin
			case (k)
				0: r = make_req(MR_LOAD,  SZ_BYTE,  32'h41, '0);
				1: r = make_req(MR_LOADZ, SZ_BYTE,  32'h47, '0);
				2: r = make_req(MR_LOAD,  SZ_WYDE,  32'h46, '0);
				3: r = make_req(MR_LOADZ, SZ_WYDE,  32'h42, '0);
				4: r = make_req(MR_LOAD,  SZ_TETRA, 32'h44, '0);
				default: r = make_req(MR_LOADZ, SZ_TETRA, 32'h40, '0);
			endcase
			issue(k % 2, r);
			@(negedge clk);
			expect_true(rsp_valid && rsp.tag == r.tag, "forwarded load not on rsp 2 cycles later");
		end
		stall = 1'b0;
		drain();
		finish_test("store forwarding", e0);

		e0 = errors;
		issue(0, make_req(MR_STORE, SZ_WYDE, 32'h82, 64'h9abc));
		issue(1, make_req(MR_STORE, SZ_TETRA, 32'h1f4, 64'h1357_9bdf));
		drain();
		issued.delete();
		got.delete();
		issue(0, make_req(MR_LOAD, SZ_OCTA, 32'h80, '0));
		issue(1, make_req(MR_LOADZ, SZ_TETRA, 32'h1f4, '0));
		issue(0, make_req(MR_LOAD, SZ_BYTE, 32'h3a7, '0));
		issue(0, make_req(MR_LOAD, SZ_WYDE, 32'h82, '0));
		drain();
		expect_true(got == issued, "memory load results out of acceptance order");
		finish_test("memory loads", e0);

		e0 = errors;
		r = make_req(MR_STORE, SZ_TETRA, 32'h100, 64'hfedc_ba98);
		q = make_req(MR_LOAD, SZ_WYDE, 32'h102, '0);
		@(posedge clk);
		wr0 <= 1'b1;
		i0  <= r;
		wr1 <= 1'b1;
		i1  <= q;
		do @(negedge clk); while (!wr_ack0 && !wr_ack1);
		expect_true(wr_ack0 && !wr_ack1, "port 1 acknowledged while port 0 offered");
		record(r);
		@(posedge clk);
		wr0 <= 1'b0;
		do @(negedge clk); while (!wr_ack1);
		record(q);
		@(posedge clk);
		wr1 <= 1'b0;
		drain();
		finish_test("port priority", e0);

		e0 = errors;
		stall = 1'b1;
		for (int k = 0; k < QDEP; k++)
			issue(k % 2, make_req(MR_LOAD, SZ_OCTA, 32'(k * 8 + 32'h200), '0));
		@(negedge clk);
		expect_true(full, "full not raised after QDEP requests");
		r = make_req(MR_LOADZ, SZ_BYTE, 32'h305, '0);
		@(posedge clk);
		wr0 <= 1'b1;
		i0  <= r;
		repeat (6) begin
			@(negedge clk);
			expect_true(!wr_ack0 && full && wb_o.cyc, "offer acknowledged or bus dropped while full");
		end
		stall = 1'b0;
		do @(negedge clk); while (!wr_ack0);
		record(r);
		@(posedge clk);
		wr0 <= 1'b0;
		drain();
		finish_test("queue full", e0);

		e0 = errors;
		stall = 1'b1;
		issue(0, make_req(MR_STORE, SZ_WYDE, 32'h4c, 64'h1111));
		r = make_req(MR_STORE, SZ_TETRA, 32'h4c, 64'h8765_4321);
		@(posedge clk);
		wr1 <= 1'b1;
		i1  <= r;
		repeat (6) begin
			@(negedge clk);
			expect_true(!wr_ack1, "overlapping store acknowledged before the first drained");
		end
		stall = 1'b0;
		do @(negedge clk); while (!wr_ack1);
		// The first store must already sit in memory when the second is taken
		expect_true(mem_b[11'h4c] == 8'h11 && mem_b[11'h4d] == 8'h11,
			"second store taken before the first reached memory");
		record(r);
		@(posedge clk);
		wr1 <= 1'b0;
		drain();
		issue(0, make_req(MR_LOAD, SZ_TETRA, 32'h4c, '0));
		drain();
		finish_test("overlapping store", e0);

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
			errors, dut_i.asserts_i.fails);
		if (errors == 0 && dut_i.asserts_i.fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
mem_req_pkg.sv
wb_pkg.sv
mem_req_queue.sv
wb_mem_master.sv
load_result_merge.sv
mem_req_subsys.sv
mem_req_asserts.sv
tb_mem_req_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
	--top-module tb_mem_req_subsys -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1
